// File: Makefile
# Verilator build for the SAD trigger testbench
VERILATOR  ?= verilator
FILELIST   ?= src.f
TB_TOP     ?= sad_tb
RTL_TOP    ?= sad_trigger_top
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing -j 0 -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(OBJ_DIR)

# a $fatal in the testbench gives a non-zero exit status
run: build
	./$(OBJ_DIR)/V$(TB_TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: common/sad_consts.svh
`ifndef SAD_CONSTS_SVH
`define SAD_CONSTS_SVH

// window and datapath sizes
`define SAD_REF_SAMPLES     32
`define SAD_SAMPLE_BITS     8
`define SAD_COUNTER_BITS    16  // msb doubles as the saturation flag
`define SAD_IDX_BITS        7   // byte index on the register port

// edges from the capture of a window's last sample to the trigger pulse
`define SAD_TRIGGER_LATENCY 5

// register map
`define SAD_ADDR_REFERENCE         8'h40
`define SAD_ADDR_REFEN             8'h41
`define SAD_ADDR_THRESHOLD         8'h42
`define SAD_ADDR_STATUS            8'h43
`define SAD_ADDR_MULTIPLE_TRIGGERS 8'h44
`define SAD_ADDR_ALWAYS_ARMED      8'h45

`endif

// File: common/sad_pkg.sv
`include "sad_consts.svh"

package sad_pkg;

    typedef logic [`SAD_SAMPLE_BITS-1:0]  sample_t;    // adc or reference sample
    typedef logic [`SAD_COUNTER_BITS-1:0] score_t;     // sad accumulator / threshold
    typedef logic [`SAD_REF_SAMPLES-1:0]  lane_vec_t;  // one bit per lane
    typedef logic [4:0]                   lane_idx_t;  // lane or reference position
    typedef logic [`SAD_IDX_BITS-1:0]     byte_idx_t;

    // one register port access, single cycle strobes
    typedef struct packed {
        logic       write;
        logic       read;
        logic [7:0] addr;
        byte_idx_t  index;
        logic [7:0] data;
    } reg_bus_t;

    typedef struct packed {
        logic [`SAD_REF_SAMPLES*`SAD_SAMPLE_BITS-1:0] reference;
        lane_vec_t                                    refen;      // per-position compare enable
        score_t                                       threshold;
        logic                                         multiple_triggers;
        logic                                         always_armed;
    } sad_cfg_t;

    // reference sample and its enable, handed down the lane chain
    typedef struct packed {
        sample_t ref_sample;
        logic    en;
    } lane_feed_t;

endpackage

// File: logic/sad_match_status.sv
`include "sad_consts.svh"

module sad_match_status
    import sad_pkg::*;
(
    input  logic        adc_sampleclk,
    input  logic        reset,
    input  lane_vec_t   match,
    input  logic        run,
    input  logic        arm_rise,
    input  logic        status_clear,
    input  logic        multiple_triggers,
    output logic        trigger,
    output logic [23:0] status_word
);

    logic        triggered;
    logic [15:0] trig_count;
    logic        single_block;
    logic        run_q;  // run in the cycle the lanes set match

    // in single mode the pulse in flight already counts as the first one
    assign single_block = !multiple_triggers && (triggered || trigger);

    assign status_word = {trig_count, 7'b0, triggered};

    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            run_q   <= 1'b0;
            trigger <= 1'b0;
        end else begin
            run_q   <= run;
            trigger <= run && run_q && (|match) && !single_block;
        end
    end

    always_ff @(posedge adc_sampleclk) begin
        if (reset || status_clear || arm_rise) begin
            triggered  <= 1'b0;
            trig_count <= '0;
        end else if (trigger) begin
            triggered  <= 1'b1;
            trig_count <= trig_count + 1'b1;  // wraps
        end
    end

endmodule

// File: logic/sad_regs.sv
`include "sad_consts.svh"

module sad_regs
    import sad_pkg::*;
(
    input  logic        adc_sampleclk,
    input  logic        reset,
    input  reg_bus_t    reg_bus,
    input  logic [23:0] status_byte_sel,
    output logic [7:0]  reg_datao,
    output sad_cfg_t    cfg,
    output logic        status_clear
);

    logic [`SAD_REF_SAMPLES*`SAD_SAMPLE_BITS-1:0] ref_q;
    lane_vec_t   refen_q;
    score_t      threshold_q;
    logic        multiple_q;
    logic        always_armed_q;
    logic [31:0] threshold_wide;  // software sees a 32 bit threshold
    byte_idx_t   idx;

    assign idx = reg_bus.index;
    assign threshold_wide = {{(32-`SAD_COUNTER_BITS){1'b0}}, threshold_q};

    assign cfg.reference         = ref_q;
    assign cfg.refen             = refen_q;
    assign cfg.threshold         = threshold_q;
    assign cfg.multiple_triggers = multiple_q;
    assign cfg.always_armed      = always_armed_q;

    // byte-wise writes, out of range bytes are dropped
    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            ref_q          <= '0;
            refen_q        <= '1;  // every position compared by default
            threshold_q    <= '0;
            multiple_q     <= 1'b0;
            always_armed_q <= 1'b0;
        end else if (reg_bus.write) begin
            case (reg_bus.addr)
                `SAD_ADDR_REFERENCE: begin
                    if (idx < (`SAD_REF_SAMPLES * `SAD_SAMPLE_BITS / 8))
                        ref_q[idx*8 +: 8] <= reg_bus.data;
                end
                `SAD_ADDR_REFEN: begin
                    if (idx < (`SAD_REF_SAMPLES / 8))
                        refen_q[idx*8 +: 8] <= reg_bus.data;
                end
                `SAD_ADDR_THRESHOLD: begin
                    if (idx < (`SAD_COUNTER_BITS / 8))
                        threshold_q[idx*8 +: 8] <= reg_bus.data;
                end
                `SAD_ADDR_MULTIPLE_TRIGGERS: multiple_q <= reg_bus.data[0];
                `SAD_ADDR_ALWAYS_ARMED:      always_armed_q <= reg_bus.data[0];
                default: ;
            endcase
        end
    end

    // any write to the status address clears it
    always_ff @(posedge adc_sampleclk) begin
        if (reset)
            status_clear <= 1'b0;
        else
            status_clear <= reg_bus.write && (reg_bus.addr == `SAD_ADDR_STATUS);
    end

    always_comb begin
        reg_datao = 8'h00;
        if (reg_bus.read) begin
            case (reg_bus.addr)
                `SAD_ADDR_REFERENCE: begin
                    if (idx < (`SAD_REF_SAMPLES * `SAD_SAMPLE_BITS / 8))
                        reg_datao = ref_q[idx*8 +: 8];
                end
                `SAD_ADDR_REFEN: begin
                    if (idx < (`SAD_REF_SAMPLES / 8))
                        reg_datao = refen_q[idx*8 +: 8];
                end
                `SAD_ADDR_THRESHOLD: begin
                    if (idx < 4)
                        reg_datao = threshold_wide[idx*8 +: 8];
                end
                `SAD_ADDR_STATUS: begin
                    if (idx < 3)  // {count, 7'b0, triggered}
                        reg_datao = status_byte_sel[idx*8 +: 8];
                end
                default: ;
            endcase
        end
    end

endmodule

// File: logic/sad_trigger_top.sv
`include "sad_consts.svh"

module sad_trigger_top
    import sad_pkg::*;
(
    input  logic       adc_sampleclk,
    input  logic       reset,
    input  sample_t    adc_datain,
    input  logic       armed_and_ready,
    input  logic       active,
    input  logic       xadc_error,
    input  reg_bus_t   reg_bus,
    output logic [7:0] reg_datao,
    output logic       trigger
);

    sad_cfg_t    cfg;
    logic [23:0] status_word;
    logic        status_clear;
    sample_t     sample_q;
    lane_feed_t  feed0;
    lane_vec_t   restart;
    lane_vec_t   window_full;
    lane_vec_t   match;
    logic        run;
    logic        arm_rise;
    lane_feed_t  feed_q [`SAD_REF_SAMPLES];  // each lane's registered feed

    sad_regs i_sad_regs (
        .adc_sampleclk   (adc_sampleclk),
        .reset           (reset),
        .reg_bus         (reg_bus),
        .status_byte_sel (status_word),
        .reg_datao       (reg_datao),
        .cfg             (cfg),
        .status_clear    (status_clear)
    );

    sad_sequencer i_sad_sequencer (
        .adc_sampleclk   (adc_sampleclk),
        .reset           (reset),
        .adc_datain      (adc_datain),
        .armed_and_ready (armed_and_ready),
        .active          (active),
        .xadc_error      (xadc_error),
        .cfg             (cfg),
        .sample_q        (sample_q),
        .feed0           (feed0),
        .restart         (restart),
        .window_full     (window_full),
        .run             (run),
        .arm_rise        (arm_rise)
    );

    for (genvar i = 0; i < `SAD_REF_SAMPLES; i++) begin : g_lane
        lane_feed_t feed_in;

        if (i == 0) begin : g_head
            assign feed_in = feed0;
        end else begin : g_chain
            assign feed_in = feed_q[i-1];
        end

        sad_lane i_sad_lane (
            .adc_sampleclk (adc_sampleclk),
            .sample_q      (sample_q),
            .feed_in       (feed_in),
            .feed_q        (feed_q[i]),
            .restart       (restart[i]),
            .window_full   (window_full[i]),
            .threshold     (cfg.threshold),
            .match         (match[i])
        );
    end

    sad_match_status i_sad_match_status (
        .adc_sampleclk     (adc_sampleclk),
        .reset             (reset),
        .match             (match),
        .run               (run),
        .arm_rise          (arm_rise),
        .status_clear      (status_clear),
        .multiple_triggers (cfg.multiple_triggers),
        .trigger           (trigger),
        .status_word       (status_word)
    );

endmodule

// File: sad_core/sad_lane.sv
`include "sad_consts.svh"

module sad_lane
    import sad_pkg::*;
(
    input  logic       adc_sampleclk,
    input  sample_t    sample_q,
    input  lane_feed_t feed_in,
    output lane_feed_t feed_q,
    input  logic       restart,
    input  logic       window_full,
    input  score_t     threshold,
    output logic       match
);

    logic       above;     // sample greater than reference
    sample_t    sample_d;
    lane_feed_t feed_d;
    sample_t    diff;
    score_t     acc;

    // the feed walks down the lanes, so lane i sees the reference
    // position i steps behind lane 0
    always_ff @(posedge adc_sampleclk) begin
        feed_q <= feed_in;
    end

    // compare stage
    always_ff @(posedge adc_sampleclk) begin
        above    <= sample_q > feed_q.ref_sample;
        sample_d <= sample_q;
        feed_d   <= feed_q;
    end

    // difference stage
    always_ff @(posedge adc_sampleclk) begin
        if (!feed_d.en)
            diff <= '0;  // masked position adds nothing
        else if (above)
            diff <= sample_d - feed_d.ref_sample;
        else
            diff <= feed_d.ref_sample - sample_d;
    end

    // accumulate stage
    always_ff @(posedge adc_sampleclk) begin
        if (restart)
            acc <= score_t'(diff);  // first sample of a new window
        else if (!acc[`SAD_COUNTER_BITS-1])
            acc <= acc + score_t'(diff);
        // once the msb is set the score holds
    end

    // restart one cycle on means acc holds a whole window
    always_ff @(posedge adc_sampleclk) begin
        match <= window_full && restart && (acc <= threshold);
    end

endmodule

// File: sad_core/sad_sequencer.sv
`include "sad_consts.svh"

module sad_sequencer
    import sad_pkg::*;
(
    input  logic       adc_sampleclk,
    input  logic       reset,
    input  sample_t    adc_datain,
    input  logic       armed_and_ready,
    input  logic       active,
    input  logic       xadc_error,
    input  sad_cfg_t   cfg,
    output sample_t    sample_q,
    output lane_feed_t feed0,
    output lane_vec_t  restart,
    output lane_vec_t  window_full,
    output logic       run,
    output logic       arm_rise
);

    logic      arm_q;
    logic      arm_qq;
    lane_idx_t pos;  // reference position handed to lane 0

    assign run      = (arm_q || cfg.always_armed) && active && !xadc_error;
    assign arm_rise = arm_q && !arm_qq;

    assign feed0.ref_sample = cfg.reference[pos*`SAD_SAMPLE_BITS +: `SAD_SAMPLE_BITS];
    assign feed0.en         = cfg.refen[pos];

    always_ff @(posedge adc_sampleclk) begin
        sample_q <= adc_datain;
    end

    always_ff @(posedge adc_sampleclk) begin
        if (reset) begin
            arm_q  <= 1'b0;
            arm_qq <= 1'b0;
        end else begin
            arm_q  <= armed_and_ready;
            arm_qq <= arm_q;
        end
    end

    // restart idles three lanes behind lane 0, matching the compare,
    // difference and accumulate stages before lane 0 loads its first sample
    always_ff @(posedge adc_sampleclk) begin
        if (reset || !run) begin
            pos         <= '0;
            restart     <= lane_vec_t'(1) << (`SAD_REF_SAMPLES - 3);
            window_full <= '0;
        end else begin
            restart     <= {restart[`SAD_REF_SAMPLES-2:0], restart[`SAD_REF_SAMPLES-1]};
            // lane 0 goes full first, the rest follow one per cycle
            window_full <= {window_full[`SAD_REF_SAMPLES-2:0],
                            window_full[0] || (pos == lane_idx_t'(`SAD_REF_SAMPLES - 1))};
            if (pos == lane_idx_t'(`SAD_REF_SAMPLES - 1))
                pos <= '0;
            else
                pos <= pos + 1'b1;
        end
    end

endmodule

// File: src.f
+incdir+common
common/sad_pkg.sv
logic/sad_regs.sv
sad_core/sad_sequencer.sv
sad_core/sad_lane.sv
logic/sad_match_status.sv
logic/sad_trigger_top.sv
tests/tb_clock_gen.sv
tests/sad_tb.sv

// File: tests/sad_tb.sv
`include "sad_consts.svh"

module sad_tb
    import sad_pkg::*;
();

    localparam int N               = `SAD_REF_SAMPLES;
    localparam int CLK_PERIOD      = 100;
    localparam int STREAM_CYCLES   = 600;  // per streaming phase, four of them
    localparam int SETUP_CYCLES    = 400;  // reset, register traffic and idle gaps
    localparam int WATCHDOG_CYCLES = (4 * STREAM_CYCLES + SETUP_CYCLES) * 3 / 2;

    logic       adc_sampleclk;
    logic       reset;
    sample_t    adc_datain;
    logic       armed_and_ready;
    logic       active;
    logic       xadc_error;
    reg_bus_t   reg_bus;
    logic [7:0] reg_datao;
    logic       trigger;

    sample_t    ref_mem [N];  // model copy of the configuration
    lane_vec_t  mask;
    score_t     threshold;
    logic       multiple;
    sample_t    hist [$];     // last samples since run rose
    int         due_q [$];    // edges with a predicted trigger
    int         cyc;
    logic       mdl_triggered;
    int         mdl_count;
    int         total_fired;
    logic       rd_pending;
    logic [7:0] rd_expect;

    tb_clock_gen i_tb_clock_gen (.adc_sampleclk(adc_sampleclk));

    sad_trigger_top i_sad_trigger_top (
        .adc_sampleclk   (adc_sampleclk),
        .reset           (reset),
        .adc_datain      (adc_datain),
        .armed_and_ready (armed_and_ready),
        .active          (active),
        .xadc_error      (xadc_error),
        .reg_bus         (reg_bus),
        .reg_datao       (reg_datao),
        .trigger         (trigger)
    );

    task automatic report_failure();
        $display("Checks failed");
        $fatal(1, "run stopped at the first error");
    endtask

    function automatic int window_score();
        int acc;
        int d;
        acc = 0;
        for (int j = 0; j < N; j++) begin
            d = int'(hist[j]) - int'(ref_mem[j]);
            if (d < 0)
                d = -d;
            if (!mask[j])
                d = 0;
            if (acc < (1 << (`SAD_COUNTER_BITS - 1)))  // sum freezes at 2^15
                acc += d;
        end
        return acc;
    endfunction

    // one clock: check what the last edge produced, then drive the next one
    task automatic cycle(sample_t s, logic act, logic err, reg_bus_t rb, logic [7:0] rd_exp);
        logic due;
        @(negedge adc_sampleclk);
        cyc++;
        due = 1'b0;
        if (due_q.size() > 0 && due_q[0] == cyc) begin
            due_q.delete(0);
            due = multiple || !mdl_triggered;  // single mode keeps the first only
        end
        if (due) begin
            mdl_triggered = 1'b1;
            mdl_count++;
        end
        assert (trigger === due) else begin
            $display("ERR trigger at edge %0d: got %h expected %h", cyc, trigger, due);
            report_failure();
        end
        total_fired += int'(trigger);
        if (rd_pending) begin
            assert (reg_datao === rd_expect) else begin
                $display("ERR reg_datao addr %h index %h: got %h expected %h",
                         reg_bus.addr, reg_bus.index, reg_datao, rd_expect);
                report_failure();
            end
        end
        rd_pending = rb.read;
        rd_expect  = rd_exp;
        adc_datain = s;
        active     = act;
        xadc_error = err;
        reg_bus    = rb;
        if (!act || err) begin  // run low drops the window and anything in flight
            hist.delete();
            due_q.delete();
        end else begin
            hist.push_back(s);
            if (hist.size() > N)
                hist.delete(0);
            if (hist.size() == N && window_score() <= int'(threshold))
                due_q.push_back(cyc + 1 + `SAD_TRIGGER_LATENCY);
        end
    endtask

    function automatic sample_t random_sample();
        return sample_t'($urandom_range(255));
    endfunction

    task automatic idle(int n);
        for (int i = 0; i < n; i++)
            cycle(random_sample(), 1'b0, 1'b0, '0, 8'h00);
    endtask

    task automatic write_reg(logic [7:0] addr, int idx, logic [7:0] data);
        reg_bus_t rb;
        rb       = '0;
        rb.write = 1'b1;
        rb.addr  = addr;
        rb.index = byte_idx_t'(idx);
        rb.data  = data;
        cycle(random_sample(), 1'b0, 1'b0, rb, 8'h00);
    endtask

    // checked on the following clock
    task automatic expect_byte(logic [7:0] addr, int idx, logic [7:0] exp);
        reg_bus_t rb;
        rb       = '0;
        rb.read  = 1'b1;
        rb.addr  = addr;
        rb.index = byte_idx_t'(idx);
        cycle(random_sample(), 1'b0, 1'b0, rb, exp);
    endtask

    task automatic check_status();
        expect_byte(`SAD_ADDR_STATUS, 0, {7'b0, mdl_triggered});
        expect_byte(`SAD_ADDR_STATUS, 1, 8'(mdl_count));
        expect_byte(`SAD_ADDR_STATUS, 2, 8'(mdl_count >> 8));
        idle(1);
    endtask

    task automatic load_mask(lane_vec_t m);
        mask = m;
        for (int b = 0; b < N / 8; b++)
            write_reg(`SAD_ADDR_REFEN, b, m[b*8 +: 8]);
    endtask

    task automatic load_threshold(score_t t);
        threshold = t;
        write_reg(`SAD_ADDR_THRESHOLD, 0, t[7:0]);
        write_reg(`SAD_ADDR_THRESHOLD, 1, t[15:8]);
    endtask

    task automatic set_multiple(logic m);
        multiple = m;
        write_reg(`SAD_ADDR_MULTIPLE_TRIGGERS, 0, {7'b0, m});
    endtask

    // random stream with the reference pattern dropped in now and then
    task automatic stream(int n, logic masked_err, logic gate);
        int      emb_pos;
        int      gap;
        int      v;
        int      kind;
        logic    act;
        logic    err;
        sample_t s;
        emb_pos = -1;
        gap     = 0;
        for (int i = 0; i < n; i++) begin
            if (emb_pos < 0 && $urandom_range(23) == 0)
                emb_pos = 0;
            if (emb_pos < 0) begin
                s = random_sample();
            end else begin
                v = int'(ref_mem[emb_pos]) + int'($urandom_range(6)) - 3;  // small noise
                if (v < 0)
                    v = 0;
                if (v > 255)
                    v = 255;
                s = sample_t'(v);
                if (masked_err && !mask[emb_pos])
                    s = ref_mem[emb_pos] ^ 8'h80;  // far off, but not compared
                emb_pos = (emb_pos == N - 1) ? -1 : emb_pos + 1;
            end
            if (gate && gap == 0 && $urandom_range(119) == 0)
                gap = int'($urandom_range(9, 2));  // run drops on the even counts
            act = 1'b1;
            err = 1'b0;
            if (gap > 0) begin
                if (!gap[0]) begin
                    kind = int'($urandom_range(2));  // active low, error high, or both
                    act  = (kind == 1);
                    err  = (kind != 0);
                end
                gap--;
            end
            cycle(s, act, err, '0, 8'h00);
        end
    endtask

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, the test did not finish", WATCHDOG_CYCLES);
        report_failure();
    end

    initial begin
        lane_vec_t holes;
        void'($urandom(32'h482b_6c95));
        reset           = 1'b1;
        adc_datain      = '0;
        armed_and_ready = 1'b0;
        active          = 1'b0;
        xadc_error      = 1'b0;
        reg_bus         = '0;
        mask            = '1;
        threshold       = '0;
        multiple        = 1'b0;
        cyc             = 0;
        mdl_triggered   = 1'b0;
        mdl_count       = 0;
        total_fired     = 0;
        rd_pending      = 1'b0;
        rd_expect       = 8'h00;
        for (int j = 0; j < N; j++)
            ref_mem[j] = '0;
        idle(5);
        reset = 1'b0;

        // register write and read-back
        for (int b = 0; b < N / 8; b++)
            expect_byte(`SAD_ADDR_REFEN, b, 8'hff);
        check_status();
        for (int j = 0; j < N; j++) begin
            ref_mem[j] = random_sample();
            write_reg(`SAD_ADDR_REFERENCE, j, ref_mem[j]);
        end
        load_mask(lane_vec_t'($urandom()));
        load_threshold(score_t'($urandom()));
        for (int j = 0; j < N; j++)
            expect_byte(`SAD_ADDR_REFERENCE, j, ref_mem[j]);
        for (int b = 0; b < N / 8; b++)
            expect_byte(`SAD_ADDR_REFEN, b, mask[b*8 +: 8]);
        for (int b = 0; b < 4; b++)
            expect_byte(`SAD_ADDR_THRESHOLD, b, (b < 2) ? threshold[b*8 +: 8] : 8'h00);
        idle(2);

        // matching windows, then masked positions with large errors
        write_reg(`SAD_ADDR_ALWAYS_ARMED, 0, 8'h01);
        set_multiple(1'b1);
        load_mask('1);
        load_threshold(score_t'($urandom_range(220, 80)));
        stream(STREAM_CYCLES, 1'b0, 1'b0);
        idle(4);
        check_status();
        holes = '1;
        for (int k = 0; k < 8; k++)
            holes[$urandom_range(N - 1)] = 1'b0;
        load_mask(holes);
        stream(STREAM_CYCLES, 1'b1, 1'b0);
        idle(4);
        check_status();

        // clear by write, then single-trigger mode
        write_reg(`SAD_ADDR_STATUS, 0, 8'h00);
        mdl_triggered = 1'b0;
        mdl_count     = 0;
        idle(3);
        check_status();
        set_multiple(1'b0);
        stream(STREAM_CYCLES, 1'b0, 1'b0);
        idle(4);
        check_status();
        assert (mdl_count == 1) else begin
            $display("single-trigger phase produced no matching window");
            report_failure();
        end

        // re-arm clears status, then gated stream with multiple triggers
        armed_and_ready = 1'b1;
        mdl_triggered   = 1'b0;
        mdl_count       = 0;
        idle(4);
        check_status();
        set_multiple(1'b1);
        stream(STREAM_CYCLES, 1'b0, 1'b1);
        idle(4);
        check_status();

        if (total_fired > 0) begin
            $display("All checks passed");
            $finish;
        end else begin
            $display("no trigger pulse was seen during the whole run");
            report_failure();
        end
    end

endmodule

// File: tests/tb_clock_gen.sv
module tb_clock_gen (
    output logic adc_sampleclk
);

    // period of 100 time units
    initial begin
        adc_sampleclk = 1'b0;
        forever #50 adc_sampleclk = ~adc_sampleclk;
    end

endmodule
